// ==== fpm_pkg.sv ====
/*
	exponent section shared definitions
	opcode and sequencer state enums
	exponent, extended sum and shift count widths
*/

package fpm_pkg;

	// --------------------
	// widths
	localparam int EXP_W = 8;
	localparam int EXT_W = EXP_W + 2;
	localparam int SHIFT_W = 6;

	// difference magnitude at which the smaller operand is lost
	localparam int SHIFT_OUT = 40;

	// --------------------
	// floating-point operations handled by the exponent section
	typedef enum logic [1:0] {
		OP_AF = 2'd0,
		OP_SF = 2'd1,
		OP_MF = 2'd2,
		OP_DF = 2'd3
	} fpm_op_e;

	// sequencer steps, one per clock
	typedef enum logic [2:0] {
		IDLE   = 3'd0,
		LOAD_A = 3'd1,
		LOAD_B = 3'd2,
		CALC   = 3'd3,
		EVAL   = 3'd4,
		ALIGN  = 3'd5,
		FINISH = 3'd6
	} fpm_state_e;

endpackage

// ==== fpm_step_if.sv ====
/*
	step bus between sequencer, exponent data path and align control
	load/calc/eval strobes, opcode, extended sum
*/

`timescale 1ns/100ps

interface fpm_step_if;

	// single-cycle strobes from the sequencer
	logic ld_a;
	logic ld_b;
	logic calc;
	logic eval;

	// opcode held for the whole operation
	fpm_pkg::fpm_op_e op;

	// extended sum, D register with positions -1 and -2 on top
	logic [fpm_pkg::EXT_W-1:0] sum;

	modport seq (output ld_a, ld_b, calc, eval, op);
	modport path (input ld_a, ld_b, calc, op, output sum);
	modport align (input eval, op, sum);

endinterface

// ==== fic_counter.sv ====
/*
	alignment counter
	loadable down counter, one shift pulse per decrement
*/

`timescale 1ns/100ps

module fic_counter (
	input  logic                        clk_0_f,
	input  logic                        _0_f,
	input  logic                        load,
	input  logic [fpm_pkg::SHIFT_W-1:0] value,
	output logic                        shift,
	output logic                        zero
);

	logic [fpm_pkg::SHIFT_W-1:0] count;

	// shift follows each decrement by one cycle
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			count <= '0;
			shift <= 1'b0;
		end else if (load) begin
			count <= value;
			shift <= 1'b0;
		end else if (count != '0) begin
			count <= count - 1'b1;
			shift <= 1'b1;
		end else begin
			shift <= 1'b0;
		end
	end

	assign zero = (count == '0);

endmodule

// ==== fpm_seq.sv ====
/*
	exponent section sequencer
	start strobe -> load A, load B, calc, eval, align wait, done
*/

`timescale 1ns/100ps

module fpm_seq (
	input  logic             clk_0_f,
	input  logic             _0_f,
	input  logic             start,
	input  fpm_pkg::fpm_op_e op,
	input  logic             need_align,
	input  logic             fic_zero,
	output logic             busy,
	output logic             done,
	fpm_step_if.seq          step
);

	fpm_pkg::fpm_state_e state;
	fpm_pkg::fpm_op_e op_q;

	// --------------------
	// state register, opcode captured with start
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			state <= fpm_pkg::IDLE;
			op_q <= fpm_pkg::OP_AF;
		end else begin
			case (state)
				fpm_pkg::IDLE: begin
					if (start) begin
						op_q <= op;
						state <= fpm_pkg::LOAD_A;
					end
				end
				fpm_pkg::LOAD_A: state <= fpm_pkg::LOAD_B;
				fpm_pkg::LOAD_B: state <= fpm_pkg::CALC;
				fpm_pkg::CALC: state <= fpm_pkg::EVAL;
				fpm_pkg::EVAL: state <= fpm_pkg::ALIGN;
				fpm_pkg::ALIGN: begin
					// wait for the last shift pulse when an alignment runs
					if (!need_align || fic_zero) begin
						state <= fpm_pkg::FINISH;
					end
				end
				fpm_pkg::FINISH: state <= fpm_pkg::IDLE;
				default: state <= fpm_pkg::IDLE;
			endcase
		end
	end

	// --------------------
	// step strobes decoded from the state
	assign step.ld_a = (state == fpm_pkg::LOAD_A);
	assign step.ld_b = (state == fpm_pkg::LOAD_B);
	assign step.calc = (state == fpm_pkg::CALC);
	assign step.eval = (state == fpm_pkg::EVAL);
	assign step.op = op_q;

	// busy drops in the done cycle
	assign busy = (state != fpm_pkg::IDLE) && (state != fpm_pkg::FINISH);
	assign done = (state == fpm_pkg::FINISH);

endmodule

// ==== fpm_exp_path.sv ====
/*
	exponent data path
	L bus, D and B registers
	extended exponent adder, result exponent register
*/

`timescale 1ns/100ps

module fpm_exp_path (
	input  logic                      clk_0_f,
	input  logic                      _0_f,
	input  logic [fpm_pkg::EXP_W-1:0] exp_a,
	input  logic [fpm_pkg::EXP_W-1:0] exp_b,
	fpm_step_if.path                  step,
	output logic [fpm_pkg::EXP_W-1:0] exp_res
);

	logic [fpm_pkg::EXT_W-1:0] l_bus;
	logic [fpm_pkg::EXT_W-1:0] d;
	logic [fpm_pkg::EXP_W-1:0] b;
	logic [fpm_pkg::EXT_W-1:0] d_in;
	logic [fpm_pkg::EXP_W:0] low_sum;
	logic [fpm_pkg::EXT_W-1:0] sum_c;
	logic sub;
	logic c_1;
	logic sum_c_1;
	logic sum_c_2;

	// --------------------
	// L bus
	always_comb begin
		if (step.ld_a) begin
			l_bus = {{2{exp_a[fpm_pkg::EXP_W-1]}}, exp_a};
		end else if (step.ld_b) begin
			l_bus = {{2{exp_b[fpm_pkg::EXP_W-1]}}, exp_b};
		end else begin
			l_bus = sum_c;
		end
	end

	// D with positions -1/-2, B takes D on the second load
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			d <= '0;
			b <= '0;
		end else begin
			if (step.ld_a || step.ld_b || step.calc) begin
				d <= l_bus;
			end
			if (step.ld_b) begin
				b <= d[fpm_pkg::EXP_W-1:0];
			end
		end
	end

	// --------------------
	// adder, b holds exponent A and d holds exponent B
	// MF adds, the others subtract d from b
	assign sub = (step.op != fpm_pkg::OP_MF);
	assign d_in = sub ? ~d : d;
	assign low_sum = {1'b0, b} + {1'b0, d_in[fpm_pkg::EXP_W-1:0]} + {{fpm_pkg::EXP_W{1'b0}}, sub};

	// two extension positions, b sign-extended
	assign sum_c_1 = b[fpm_pkg::EXP_W-1] ^ d_in[fpm_pkg::EXP_W] ^ low_sum[fpm_pkg::EXP_W];
	assign c_1 = (b[fpm_pkg::EXP_W-1] & d_in[fpm_pkg::EXP_W])
		| (b[fpm_pkg::EXP_W-1] & low_sum[fpm_pkg::EXP_W])
		| (d_in[fpm_pkg::EXP_W] & low_sum[fpm_pkg::EXP_W]);
	assign sum_c_2 = b[fpm_pkg::EXP_W-1] ^ d_in[fpm_pkg::EXT_W-1] ^ c_1;
	assign sum_c = {sum_c_2, sum_c_1, low_sum[fpm_pkg::EXP_W-1:0]};

	// after calc D holds the extended sum
	assign step.sum = d;

	// --------------------
	// result exponent
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			exp_res <= '0;
		end else if (step.calc) begin
			if (step.op == fpm_pkg::OP_AF || step.op == fpm_pkg::OP_SF) begin
				// negative A-B means B is larger
				exp_res <= sum_c[fpm_pkg::EXT_W-1] ? d[fpm_pkg::EXP_W-1:0] : b;
			end else begin
				exp_res <= sum_c[fpm_pkg::EXP_W-1:0];
			end
		end
	end

endmodule

// ==== fpm_align_ctl.sv ====
/*
	align control
	g/wdt flags and shift count for AF and SF
	overflow and underflow flags for MF and DF
*/

`timescale 1ns/100ps

module fpm_align_ctl (
	input  logic                        clk_0_f,
	input  logic                        _0_f,
	fpm_step_if.align                   step,
	input  logic                        fic_zero,
	input  logic                        shift_pulse,
	output logic                        g,
	output logic                        wdt,
	output logic                        ovf,
	output logic                        unf,
	output logic [fpm_pkg::SHIFT_W-1:0] shift_cnt,
	output logic                        need_align,
	output logic                        fic_load,
	output logic [fpm_pkg::SHIFT_W-1:0] fic_value
);

	logic [fpm_pkg::EXT_W-1:0] mag;
	logic af_sf;
	logic ge_40;
	logic [fpm_pkg::SHIFT_W-1:0] cnt_next;

	// --------------------
	// magnitude of the extended difference
	assign af_sf = (step.op == fpm_pkg::OP_AF) || (step.op == fpm_pkg::OP_SF);
	assign mag = step.sum[fpm_pkg::EXT_W-1] ? (~step.sum + 1'b1) : step.sum;
	assign ge_40 = (mag >= fpm_pkg::SHIFT_OUT);

	// operand shifted out entirely, nothing to count
	assign cnt_next = ge_40 ? '0 : mag[fpm_pkg::SHIFT_W-1:0];

	assign fic_load = step.eval && af_sf;
	assign fic_value = cnt_next;

	// --------------------
	// flags, held until the next eval
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			g <= 1'b0;
			wdt <= 1'b0;
			ovf <= 1'b0;
			unf <= 1'b0;
			shift_cnt <= '0;
		end else if (step.eval) begin
			if (af_sf) begin
				g <= ge_40;
				wdt <= step.sum[fpm_pkg::EXT_W-1];
				shift_cnt <= cnt_next;
				ovf <= 1'b0;
				unf <= 1'b0;
			end else begin
				g <= 1'b0;
				wdt <= 1'b0;
				shift_cnt <= '0;
				// result outside the 8-bit signed range
				ovf <= ($signed(step.sum) > 2 ** (fpm_pkg::EXP_W - 1) - 1);
				unf <= ($signed(step.sum) < -(2 ** (fpm_pkg::EXP_W - 1)));
			end
		end
	end

	// alignment pending until the last shift pulse
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			need_align <= 1'b0;
		end else if (step.eval) begin
			need_align <= af_sf && (cnt_next != '0);
		end else if (fic_zero && shift_pulse) begin
			need_align <= 1'b0;
		end
	end

endmodule

// ==== fpm_exp_top.sv ====
/*
	exponent section top level
	sequencer, data path, align control, alignment counter
*/

`timescale 1ns/100ps

module fpm_exp_top (
	input  logic                        clk_0_f,
	input  logic                        _0_f,
	input  logic                        start,
	input  fpm_pkg::fpm_op_e            op,
	input  logic [fpm_pkg::EXP_W-1:0]   exp_a,
	input  logic [fpm_pkg::EXP_W-1:0]   exp_b,
	output logic [fpm_pkg::EXP_W-1:0]   exp_res,
	output logic [fpm_pkg::SHIFT_W-1:0] shift_cnt,
	output logic                        shift,
	output logic                        g,
	output logic                        wdt,
	output logic                        ovf,
	output logic                        unf,
	output logic                        busy,
	output logic                        done
);

	logic need_align;
	logic fic_zero;
	logic fic_load;
	logic [fpm_pkg::SHIFT_W-1:0] fic_value;

	fpm_step_if step_bus ();

	fpm_seq u_seq (
		.clk_0_f    (clk_0_f),
		._0_f       (_0_f),
		.start      (start),
		.op         (op),
		.need_align (need_align),
		.fic_zero   (fic_zero),
		.busy       (busy),
		.done       (done),
		.step       (step_bus)
	);

	fpm_exp_path u_path (
		.clk_0_f (clk_0_f),
		._0_f    (_0_f),
		.exp_a   (exp_a),
		.exp_b   (exp_b),
		.step    (step_bus),
		.exp_res (exp_res)
	);

	fpm_align_ctl u_align (
		.clk_0_f     (clk_0_f),
		._0_f        (_0_f),
		.step        (step_bus),
		.fic_zero    (fic_zero),
		.shift_pulse (shift),
		.g           (g),
		.wdt         (wdt),
		.ovf         (ovf),
		.unf         (unf),
		.shift_cnt   (shift_cnt),
		.need_align  (need_align),
		.fic_load    (fic_load),
		.fic_value   (fic_value)
	);

	fic_counter u_fic (
		.clk_0_f (clk_0_f),
		._0_f    (_0_f),
		.load    (fic_load),
		.value   (fic_value),
		.shift   (shift),
		.zero    (fic_zero)
	);

endmodule

// ==== fpm_checker.sv ====
/*
	exponent section checker
	snoops accepted starts and models the expected results
	counts shift pulses, busy cycles and done latency, one line per test
*/

`timescale 1ns/100ps

module fpm_checker (
	input  logic                        clk_0_f,
	input  logic                        _0_f,
	input  logic                        start,
	input  fpm_pkg::fpm_op_e            op,
	input  logic [fpm_pkg::EXP_W-1:0]   exp_a,
	input  logic [fpm_pkg::EXP_W-1:0]   exp_b,
	input  logic [8*16-1:0]             test_name,
	input  logic [fpm_pkg::EXP_W-1:0]   exp_res,
	input  logic [fpm_pkg::SHIFT_W-1:0] shift_cnt,
	input  logic                        shift,
	input  logic                        g,
	input  logic                        wdt,
	input  logic                        ovf,
	input  logic                        unf,
	input  logic                        busy,
	input  logic                        done,
	output int                          pass_count,
	output int                          fail_count
);

	logic pending;
	logic bad;
	logic [8*16-1:0] cur_name;
	int cycles;
	int pulses;
	int busy_cycles;
	int ignored;

	// expected values of the running operation
	logic [31:0] res_e;
	logic [31:0] cnt_e;
	logic g_e;
	logic wdt_e;
	logic ovf_e;
	logic unf_e;

	initial begin
		pending = 1'b0;
		pass_count = 0;
		fail_count = 0;
	end

	task automatic compare(input logic [8*10-1:0] field, input logic [31:0] expv,
		input logic [31:0] actv);
		if (expv !== actv) begin
			$display("[ERROR] %0s %0s: expected %0d, actual %0d", cur_name, field, expv, actv);
			bad = 1'b1;
		end
	endtask

	task automatic report_test();
		if (bad) begin
			fail_count++;
		end else begin
			pass_count++;
		end
		$display("test %0s: %0s, %0d shift pulses, %0d starts ignored", cur_name,
			bad ? "FAIL" : "PASS", pulses, ignored);
	endtask

	// --------------------
	// reference model of the exponent rules
	task automatic predict(input fpm_pkg::fpm_op_e o, input logic [7:0] a, input logic [7:0] b);
		int ai;
		int bi;
		int r;
		int mag;
		ai = $signed(a);
		bi = $signed(b);
		g_e = 1'b0;
		wdt_e = 1'b0;
		ovf_e = 1'b0;
		unf_e = 1'b0;
		cnt_e = 0;
		if (o == fpm_pkg::OP_AF || o == fpm_pkg::OP_SF) begin
			r = ai - bi;
			mag = (r < 0) ? -r : r;
			wdt_e = (r < 0);
			g_e = (mag >= fpm_pkg::SHIFT_OUT);
			cnt_e = g_e ? 0 : mag;
			// larger exponent wins
			res_e = (r < 0) ? b : a;
		end else begin
			r = (o == fpm_pkg::OP_MF) ? ai + bi : ai - bi;
			ovf_e = (r > 127);
			unf_e = (r < -128);
			res_e = r & 32'hff;
		end
	endtask

	task automatic start_test();
		pending = 1'b1;
		cur_name = test_name;
		cycles = 0;
		pulses = 0;
		busy_cycles = 0;
		ignored = 0;
		predict(op, exp_a, exp_b);
	endtask

	task automatic finish_test();
		bad = 1'b0;
		// edge 0 to the sample of done, plus one cycle per shift
		compare("latency", 6 + cnt_e, cycles);
		compare("exp_res", res_e, exp_res);
		compare("shift_cnt", cnt_e, shift_cnt);
		compare("shifts", cnt_e, pulses);
		compare("g", g_e, g);
		compare("wdt", wdt_e, wdt);
		compare("ovf", ovf_e, ovf);
		compare("unf", unf_e, unf);
		// busy from the edge after start up to the done cycle
		compare("busy", 5 + cnt_e, busy_cycles);
		report_test();
		pending = 1'b0;
	endtask

	// --------------------
	// outputs while reset is still applied
	always @(negedge _0_f) begin
		cur_name = "reset";
		bad = 1'b0;
		pulses = 0;
		ignored = 0;
		compare("status", 0, {busy, done, shift});
		compare("flags", 0, {g, wdt, ovf, unf});
		compare("exp_res", 0, exp_res);
		compare("shift_cnt", 0, shift_cnt);
		report_test();
	end

	always @(posedge clk_0_f) begin
		if (!_0_f) begin
			if (pending) begin
				cycles++;
				if (start) begin
					ignored++;
				end
				if (shift === 1'b1) begin
					pulses++;
				end
				if (busy === 1'b1) begin
					busy_cycles++;
				end
				if (done === 1'b1) begin
					finish_test();
				end
			end else if (start) begin
				start_test();
			end else if (done === 1'b1 || shift === 1'b1) begin
				$display("done or shift pulse seen with no operation running");
				fail_count++;
			end
		end
	end

endmodule

// ==== tb_fpm_exp.sv ====
/*
	testbench for the exponent section
	clock, reset, test data reader, LFSR operands
	stimulus driver, DUT and checker
*/

`timescale 1ns/100ps

module tb_fpm_exp;

	logic clk_0_f;
	logic _0_f;
	logic start;
	fpm_pkg::fpm_op_e op;
	logic [fpm_pkg::EXP_W-1:0] exp_a;
	logic [fpm_pkg::EXP_W-1:0] exp_b;
	logic [fpm_pkg::EXP_W-1:0] exp_res;
	logic [fpm_pkg::SHIFT_W-1:0] shift_cnt;
	logic shift;
	logic g;
	logic wdt;
	logic ovf;
	logic unf;
	logic busy;
	logic done;

	logic [8*16-1:0] test_name;
	logic [31:0] lfsr;
	logic aborted;
	int pass_count;
	int fail_count;

	fpm_exp_top dut0 (
		.clk_0_f   (clk_0_f),
		._0_f      (_0_f),
		.start     (start),
		.op        (op),
		.exp_a     (exp_a),
		.exp_b     (exp_b),
		.exp_res   (exp_res),
		.shift_cnt (shift_cnt),
		.shift     (shift),
		.g         (g),
		.wdt       (wdt),
		.ovf       (ovf),
		.unf       (unf),
		.busy      (busy),
		.done      (done)
	);

	fpm_checker chk0 (
		.clk_0_f    (clk_0_f),
		._0_f       (_0_f),
		.start      (start),
		.op         (op),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.test_name  (test_name),
		.exp_res    (exp_res),
		.shift_cnt  (shift_cnt),
		.shift      (shift),
		.g          (g),
		.wdt        (wdt),
		.ovf        (ovf),
		.unf        (unf),
		.busy       (busy),
		.done       (done),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	initial begin
		clk_0_f = 1'b0;
		forever #10 clk_0_f = ~clk_0_f;
	end

	// --------------------
	// galois LFSR, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	function automatic fpm_pkg::fpm_op_e op_of_code(input logic [1:0] c);
		case (c)
			2'd0: return fpm_pkg::OP_AF;
			2'd1: return fpm_pkg::OP_SF;
			2'd2: return fpm_pkg::OP_MF;
			default: return fpm_pkg::OP_DF;
		endcase
	endfunction

	function automatic fpm_pkg::fpm_op_e op_from_text(input logic [8*4-1:0] s);
		if (s == "SF") begin
			return fpm_pkg::OP_SF;
		end else if (s == "MF") begin
			return fpm_pkg::OP_MF;
		end else if (s == "DF") begin
			return fpm_pkg::OP_DF;
		end
		return fpm_pkg::OP_AF;
	endfunction

	// --------------------
	// stimulus
	task automatic wait_done();
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < 100) begin
			@(posedge clk_0_f);
			waited++;
			seen = (done === 1'b1);
		end
		if (!seen) begin
			$display("timeout: done never came for test %0s", test_name);
			aborted = 1'b1;
		end
	endtask

	task automatic run_op(input fpm_pkg::fpm_op_e op_v, input logic [7:0] a, input logic [7:0] b);
		@(posedge clk_0_f);
		start <= 1'b1;
		op <= op_v;
		exp_a <= a;
		exp_b <= b;
		@(posedge clk_0_f);
		start <= 1'b0;
		wait_done();
	endtask

	// second start lands in CALC, after both loads
	task automatic busy_start_test();
		test_name = "busy_start";
		@(posedge clk_0_f);
		start <= 1'b1;
		op <= fpm_pkg::OP_AF;
		exp_a <= 8'h10;
		exp_b <= 8'h08;
		@(posedge clk_0_f);
		start <= 1'b0;
		repeat (2) @(posedge clk_0_f);
		start <= 1'b1;
		op <= fpm_pkg::OP_MF;
		exp_a <= 8'h7f;
		exp_b <= 8'h7f;
		@(posedge clk_0_f);
		start <= 1'b0;
		wait_done();
		// room for a stray second done
		repeat (10) @(posedge clk_0_f);
	endtask

	initial begin
		int fd;
		int rc;
		logic [8*80-1:0] line;
		logic [8*16-1:0] first;
		logic [8*4-1:0] op_str;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] r;
		start = 1'b0;
		op = fpm_pkg::OP_AF;
		exp_a = '0;
		exp_b = '0;
		_0_f = 1'b1;
		aborted = 1'b0;
		lfsr = 32'd98968;
		test_name = "reset";
		repeat (5) @(posedge clk_0_f);
		_0_f <= 1'b0;

		fd = $fopen("fpm_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open fpm_testdata.txt");
			aborted = 1'b1;
		end else begin
			while (!$feof(fd) && !aborted) begin
				line = '0;
				rc = $fgets(line, fd);
				rc = $sscanf(line, "%s", first);
				if (rc == 1 && first != "#") begin
					rc = $sscanf(line, "%s %s %h %h", test_name, op_str, a, b);
					if (rc == 4) begin
						run_op(op_from_text(op_str), a, b);
					end
				end
			end
			$fclose(fd);
		end

		for (int i = 0; i < 16 && !aborted; i++) begin
			take_bits(2, r);
			take_bits(8, a);
			take_bits(8, b);
			$sformat(test_name, "rnd_%0d", i);
			run_op(op_of_code(r[1:0]), a, b);
		end

		if (!aborted) begin
			busy_start_test();
		end

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (!aborted && fail_count == 0 && pass_count > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== fpm_testdata.txt ====
# name opcode exp_a exp_b, opcode is AF, SF, MF or DF
# exponents are 8-bit two's complement in hex
af_equal AF 10 10
af_small_pos AF 15 10
af_small_neg AF 03 0c
sf_neg_ops SF f0 e8
sf_cross SF 05 f6
af_max_shift AF 27 00
sf_edge_neg SF 00 27
af_at_40 AF 28 00
sf_neg_40 SF d8 00
af_far AF 7f 80
sf_far_neg SF 80 7f
af_one AF 01 00
mf_simple MF 10 20
mf_ovf MF 40 40
mf_top MF 3f 40
mf_unf MF c0 bf
mf_floor MF c0 c0
mf_max MF 7f 7f
df_simple DF 20 08
df_ovf DF 7f 80
df_unf DF 80 01
df_neg DF 80 7f

// ==== sim.f ====
fpm_pkg.sv
fpm_step_if.sv
fic_counter.sv
fpm_seq.sv
fpm_exp_path.sv
fpm_align_ctl.sv
fpm_exp_top.sv
fpm_checker.sv
tb_fpm_exp.sv
